// ==== list.f ====
+incdir+include
logic/dsp_pkg.sv
logic/audio_pkg.sv
logic/sample_if.sv
logic/dsp_adder.sv
logic/wb_sample_port.sv
logic/sample_pacer.sv
logic/sigma_delta_modulator.sv
logic/sd_dac_top.sv
testbench/tb_sd_checker.sv
testbench/tb_sd_dac.sv

// ==== Makefile ====
# Verilator simulation of the sigma-delta DAC core

VERILATOR ?= verilator
TOP       ?= tb_sd_dac
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== testbench/tb_sd_dac.sv ====
// --------------------------------------------------------------------------
// Testbench for the stereo sigma-delta DAC core
// Table-driven Wishbone accesses and DC density runs
// --------------------------------------------------------------------------
`include "sd_dac_settings.svh"

module tb_sd_dac
    import audio_pkg::*;
();

    // Modulator settling time before a density window
    localparam int SETTLE_CLKS = 4096;
    localparam int ACK_LIMIT   = 8;
    // 2048 modulator ticks per DC run
    localparam int RUN_PAIRS   = 2048 / `SD_OSR;

    typedef enum int {
        ROW_WRITE,
        ROW_READ,
        ROW_FILL,
        ROW_QUIET,
        ROW_RUN,
        ROW_HOLD
    } row_op_t;

    // a is an address or left level, d is data or right level
    typedef struct {
        row_op_t op;
        int      a;
        int      d;
        int      n;
    } row_t;

    logic        clk;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    wb_addr_t    wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        dout_l;
    logic        dout_r;

    // Checker controls
    logic        rd_check;
    logic [31:0] rd_exp;
    logic        win_start;
    logic        win_quiet;
    int          win_len;
    int          lvl_l;
    int          lvl_r;
    logic        win_done;
    logic        test_end;
    int          test_num;
    logic        report;
    int          chk_errors;
    int          tb_errors;

    row_t        rows [$];
    logic [31:0] rng_state;
    int          cycle_limit;
    int          cycles;

    sd_dac_top u_sd_dac_top (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .dout_l   (dout_l),
        .dout_r   (dout_r)
    );

    tb_sd_checker #(.SETTLE_CLKS(SETTLE_CLKS)) u_tb_sd_checker (
        .clk        (clk),
        .reset      (reset),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_ack     (wb_ack),
        .wb_dat_r   (wb_dat_r),
        .dout_l     (dout_l),
        .dout_r     (dout_r),
        .rd_check   (rd_check),
        .rd_exp     (rd_exp),
        .win_start  (win_start),
        .win_quiet  (win_quiet),
        .win_len    (win_len),
        .lvl_l      (lvl_l),
        .lvl_r      (lvl_r),
        .win_done   (win_done),
        .test_end   (test_end),
        .test_num   (test_num),
        .ext_errors (tb_errors),
        .report     (report),
        .errors     (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] v;
        v = x ^ (x << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    // Level within half the feedback amplitude either way
    function automatic int random_level();
        rng_state = xorshift32(rng_state);
        return int'(rng_state % 32'd98304) - 49152;
    endfunction

    task automatic add_row(input row_op_t op, input int a, input int d, input int n);
        row_t r;
        r.op = op;
        r.a  = a;
        r.d  = d;
        r.n  = n;
        rows.push_back(r);
    endtask

    task automatic build_table();
        int rand_a;
        int rand_b;
        int rand_c;
        rng_state = 32'hec89c794;
        rand_a = random_level();
        rand_b = random_level();
        rand_c = random_level();
        // Reset state, outputs idle while disabled
        add_row(ROW_READ, int'(REG_STATUS), 0, 0);
        add_row(ROW_READ, int'(REG_CONTROL), 0, 0);
        add_row(ROW_QUIET, 0, 0, 4);
        // Overflow and its clear
        add_row(ROW_FILL, 0, 0, `SD_FIFO_DEPTH + 2);
        add_row(ROW_READ, int'(REG_STATUS), `SD_FIFO_DEPTH | (1 << 8), 0);
        add_row(ROW_QUIET, 0, 0, 4);
        add_row(ROW_WRITE, int'(REG_STATUS), 1 << 8, 0);
        add_row(ROW_READ, int'(REG_STATUS), `SD_FIFO_DEPTH, 0);
        add_row(ROW_WRITE, int'(REG_CONTROL), 1, 0);
        add_row(ROW_READ, int'(REG_CONTROL), 1, 0);
        // DC densities, equal and then split channels
        add_row(ROW_RUN, 0, 0, RUN_PAIRS);
        add_row(ROW_RUN, 40000, 40000, RUN_PAIRS);
        add_row(ROW_RUN, -45000, -45000, RUN_PAIRS);
        add_row(ROW_RUN, rand_a, rand_a, RUN_PAIRS);
        add_row(ROW_RUN, 30000, -20000, RUN_PAIRS);
        add_row(ROW_RUN, rand_b, rand_c, RUN_PAIRS);
        // FIFO runs dry, last pair keeps playing
        add_row(ROW_HOLD, rand_b, rand_c, RUN_PAIRS / 2);
        add_row(ROW_READ, int'(REG_STATUS), (1 << 16) | (1 << 9), 0);
        add_row(ROW_WRITE, int'(REG_CONTROL), 0, 0);
        add_row(ROW_WRITE, int'(REG_STATUS), 1 << 9, 0);
        add_row(ROW_READ, int'(REG_STATUS), 0, 0);
    endtask

    function automatic int cycle_budget();
        int total;
        total = 0;
        foreach (rows[i]) total += rows[i].n * `SD_MOD_DIV * `SD_OSR;
        total += rows.size() * (SETTLE_CLKS + 256) + 2000;
        return total;
    endfunction

    // --------------------------------------------------------------------------
    // Wishbone master, entered and left 1 time unit after a rising edge
    // --------------------------------------------------------------------------
    task automatic bus_access(input logic we, input wb_addr_t adr, input logic [31:0] data,
                              output logic [31:0] rdata);
        int waited;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = data;
        @(posedge clk);
        #1;
        waited = 1;
        while (!wb_ack && waited < ACK_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            $display("Bus access to register %0d was not acknowledged within %0d cycles",
                     adr, ACK_LIMIT);
            tb_errors++;
        end
        // Idle cycle, the checker samples the ack here
        @(posedge clk);
        #1;
        rd_check = 1'b0;
    endtask

    task automatic write_reg(input wb_addr_t adr, input logic [31:0] data);
        logic [31:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic read_reg(input wb_addr_t adr, output logic [31:0] data);
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic check_reg(input wb_addr_t adr, input logic [31:0] expected);
        logic [31:0] data;
        rd_exp   = expected;
        rd_check = 1'b1;
        bus_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic push_pair(input int left, input int right);
        write_reg(REG_LEFT, 32'(left));
        write_reg(REG_RIGHT, 32'(right));
    endtask

    // Window runs until the checker reports it done, topping up the FIFO if asked
    task automatic run_window(input logic quiet, input int left, input int right,
                              input int pairs, input logic feed);
        logic [31:0] st;
        lvl_l     = left;
        lvl_r     = right;
        win_quiet = quiet;
        win_len   = pairs * `SD_OSR * `SD_MOD_DIV;
        win_start = 1'b1;
        @(posedge clk);
        #1;
        win_start = 1'b0;
        while (!win_done) begin
            if (feed) begin
                read_reg(REG_STATUS, st);
                if (int'(st[7:0]) < `SD_FIFO_DEPTH) push_pair(left, right);
            end else begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic apply_row(input int idx);
        row_t r;
        int   k;
        r = rows[idx];
        case (r.op)
            ROW_WRITE: write_reg(wb_addr_t'(r.a), 32'(r.d));
            ROW_READ:  check_reg(wb_addr_t'(r.a), 32'(r.d));
            ROW_FILL: begin
                for (k = 0; k < r.n; k++) push_pair(r.a, r.d);
            end
            ROW_QUIET: run_window(1'b1, 0, 0, r.n, 1'b0);
            ROW_RUN:   run_window(1'b0, r.a, r.d, r.n, 1'b1);
            default:   run_window(1'b0, r.a, r.d, r.n, 1'b0);
        endcase
    endtask

    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int i;
        reset     = 1'b1;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        rd_check  = 1'b0;
        rd_exp    = '0;
        win_start = 1'b0;
        win_quiet = 1'b0;
        win_len   = 0;
        lvl_l     = 0;
        lvl_r     = 0;
        test_end  = 1'b0;
        test_num  = 0;
        report    = 1'b0;
        tb_errors = 0;

        build_table();
        cycle_limit = cycle_budget();

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        for (i = 0; i < rows.size(); i++) begin
            apply_row(i);
            test_num = i;
            test_end = 1'b1;
            @(posedge clk);
            #1;
            test_end = 1'b0;
        end

        report = 1'b1;
        @(posedge clk);
        #1;
        report = 1'b0;

        if (chk_errors + tb_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_sd_checker.sv ====
// --------------------------------------------------------------------------
// Result checker for the sigma-delta DAC testbench
// Watches bus and outputs and compares against expected values
// --------------------------------------------------------------------------
module tb_sd_checker #(
    parameter int SETTLE_CLKS = 4096
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_ack,
    input  logic [31:0] wb_dat_r,
    input  logic        dout_l,
    input  logic        dout_r,
    input  logic        rd_check,
    input  logic [31:0] rd_exp,
    input  logic        win_start,
    input  logic        win_quiet,
    input  int          win_len,
    input  int          lvl_l,
    input  int          lvl_r,
    output logic        win_done,
    input  logic        test_end,
    input  int          test_num,
    input  int          ext_errors,
    input  logic        report,
    output int          errors
);

    // Nominal feedback amplitude of the modulator
    localparam int  FB_AMPL = 'h18000;
    localparam real TOL     = 0.04;

    logic take_q;
    logic stb_q;
    logic win_active;
    int   skip_left;
    int   win_left;
    int   high_l;
    int   high_r;
    int   checks;
    int   tests;
    int   last_total;

    // High-time fraction should be 0.5 + x / (2 * amplitude)
    task automatic check_density(input string name, input int level, input int high,
                                 input int len);
        real expected;
        real actual;
        expected = 0.5 + real'(level) / (2.0 * real'(FB_AMPL));
        actual   = real'(high) / real'(len);
        checks++;
        if (actual < expected - TOL || actual > expected + TOL) begin
            $display("FAILED t=%0t %s expected density %0.4f got %0.4f",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_quiet(input string name, input int high);
        checks++;
        if (high != 0) begin
            $display("FAILED t=%0t %s expected 0 high clocks got %0d", $time, name, high);
            errors++;
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            take_q     = 1'b0;
            stb_q      = 1'b0;
            win_active = 1'b0;
            skip_left  = 0;
            win_left   = 0;
            high_l     = 0;
            high_r     = 0;
            checks     = 0;
            tests      = 0;
            last_total = 0;
            errors     = 0;
            win_done  <= 1'b0;
        end else begin
            // --------------------------------------------------------------
            // Bus timing and read data
            // --------------------------------------------------------------
            if (take_q) begin
                checks++;
                if (!wb_ack) begin
                    $display("FAILED t=%0t wb_ack expected 1 got 0", $time);
                    errors++;
                end
            end else if (wb_ack) begin
                $display("FAILED t=%0t wb_ack expected 0 got 1", $time);
                errors++;
            end
            // A newly raised strobe expects ack on the next clock
            take_q = wb_cyc && wb_stb && !stb_q;
            stb_q  = wb_cyc && wb_stb;

            if (wb_ack && rd_check) begin
                checks++;
                if (wb_dat_r !== rd_exp) begin
                    $display("FAILED t=%0t wb_dat_r expected 0x%08h got 0x%08h",
                             $time, rd_exp, wb_dat_r);
                    errors++;
                end
            end

            // --------------------------------------------------------------
            // Output windows after the settling time
            // --------------------------------------------------------------
            if (win_start) begin
                skip_left  = SETTLE_CLKS;
                win_left   = win_len;
                high_l     = 0;
                high_r     = 0;
                win_active = 1'b1;
                win_done  <= 1'b0;
            end else if (win_active) begin
                if (skip_left > 0) begin
                    skip_left--;
                end else begin
                    if (dout_l) high_l++;
                    if (dout_r) high_r++;
                    win_left--;
                    if (win_left == 0) begin
                        win_active = 1'b0;
                        if (win_quiet) begin
                            check_quiet("dout_l", high_l);
                            check_quiet("dout_r", high_r);
                        end else begin
                            check_density("dout_l", lvl_l, high_l, win_len);
                            check_density("dout_r", lvl_r, high_r, win_len);
                        end
                        win_done <= 1'b1;
                    end
                end
            end

            if (test_end) begin
                tests++;
                $display("test %0d: %s", test_num,
                         (errors + ext_errors == last_total) ? "passed" : "failed");
                last_total = errors + ext_errors;
            end

            if (report) begin
                $display("Summary: %0d tests, %0d checks, %0d errors",
                         tests, checks, errors + ext_errors);
            end
        end
    end

endmodule

// ==== logic/sd_dac_top.sv ====
// --------------------------------------------------------------------------
// Stereo sigma-delta DAC core with Wishbone sample port
// --------------------------------------------------------------------------
`include "sd_dac_settings.svh"

module sd_dac_top
    import audio_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  wb_addr_t    wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        dout_l,
    output logic        dout_r
);

    localparam int LEVEL_W = $clog2(`SD_FIFO_DEPTH + 1);

    logic [LEVEL_W-1:0] fifo_level;
    logic               underflow_set;
    logic               enable;

    sample_if push_if ();
    sample_if mod_if ();

    wb_sample_port #(.LEVEL_W(LEVEL_W)) u_wb_sample_port (
        .clk           (clk),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .push          (push_if.producer),
        .fifo_level    (fifo_level),
        .underflow_set (underflow_set),
        .enable        (enable)
    );

    sample_pacer #(.LEVEL_W(LEVEL_W)) u_sample_pacer (
        .clk           (clk),
        .reset         (reset),
        .enable        (enable),
        .push          (push_if.consumer),
        .mod           (mod_if.producer),
        .fifo_level    (fifo_level),
        .underflow_set (underflow_set)
    );

    sigma_delta_modulator u_sigma_delta_modulator (
        .clk     (clk),
        .reset   (reset),
        .samples (mod_if.consumer),
        .dout_l  (dout_l),
        .dout_r  (dout_r)
    );

endmodule

// ==== logic/sigma_delta_modulator.sv ====
// --------------------------------------------------------------------------
// Two-channel second-order sigma-delta modulator
// One shared adder, stepped by a seven-step program counter
// --------------------------------------------------------------------------
module sigma_delta_modulator
    import dsp_pkg::*;
    import audio_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    sample_if.consumer samples,
    output logic       dout_l,
    output logic       dout_r
);

    localparam int FB_W = $bits(sample_t) + 2;

    seq_state_t pc;
    sample_t    s_l;
    sample_t    s_r;
    acc_t       i1_l, i1_r, i2_l, i2_r;
    logic       neg_l, neg_r;
    logic [3:0] delta_cnt;
    logic [$bits(sample_t)-1:0] delta;
    logic signed [FB_W-1:0] d_fb;
    logic signed [FB_W-1:0] c_fb_l;
    logic signed [FB_W-1:0] c_fb_r;

    // Adder controls and register strobes
    dsp_op_t op;
    acc_t    dab, c, p;
    logic    ld_i1_l, ld_i2_l, ld_i1_r, ld_i2_r;

    // Dither table around 0x18000, one entry per sequence
    always_comb begin
        case (delta_cnt)
            4'h0, 4'h8: delta = 18'h18000;
            4'h1, 4'h7: delta = 18'h189cb;
            4'h2, 4'h6: delta = 18'h1921a;
            4'h3, 4'h5: delta = 18'h197a6;
            4'h4:       delta = 18'h19999;
            4'h9, 4'hf: delta = 18'h17634;
            4'ha, 4'he: delta = 18'h16de5;
            4'hb, 4'hd: delta = 18'h16859;
            default:    delta = 18'h16666;
        endcase
    end

    // Sample minus feedback, sign from the previous output
    assign d_fb   = $signed({2'b00, delta});
    assign c_fb_l = neg_l ? FB_W'(s_l) + d_fb : FB_W'(s_l) - d_fb;
    assign c_fb_r = neg_r ? FB_W'(s_r) + d_fb : FB_W'(s_r) - d_fb;

    assign samples.ready = (pc == SEQ_WAIT);

    // ------------------------------------------------------------------------
    // Step decode
    // ------------------------------------------------------------------------
    always_comb begin
        op      = DSP_NONE;
        dab     = '0;
        c       = '0;
        ld_i1_l = 1'b0;
        ld_i2_l = 1'b0;
        ld_i1_r = 1'b0;
        ld_i2_r = 1'b0;
        case (pc)
            SEQ_STEP1: begin
                op  = DSP_LOAD_C;
                dab = i1_l;
                c   = acc_t'(c_fb_l);
            end
            SEQ_STEP2: begin
                ld_i1_l = 1'b1;
                op      = DSP_ACC_ADD;
                dab     = i2_l;
            end
            SEQ_STEP3: begin
                op  = neg_l ? DSP_ACC_ADD : DSP_ACC_SUB;
                dab = acc_t'(delta);
            end
            SEQ_STEP4: begin
                // Left second integrator done, right channel starts
                ld_i2_l = 1'b1;
                op      = DSP_LOAD_C;
                dab     = i1_r;
                c       = acc_t'(c_fb_r);
            end
            SEQ_STEP5: begin
                ld_i1_r = 1'b1;
                op      = DSP_ACC_ADD;
                dab     = i2_r;
            end
            SEQ_STEP6: begin
                op  = neg_r ? DSP_ACC_ADD : DSP_ACC_SUB;
                dab = acc_t'(delta);
            end
            SEQ_STEP7: ld_i2_r = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc        <= SEQ_WAIT;
            delta_cnt <= '0;
            i1_l      <= '0;
            i2_l      <= '0;
            i1_r      <= '0;
            i2_r      <= '0;
            neg_l     <= 1'b0;
            neg_r     <= 1'b0;
            dout_l    <= 1'b0;
            dout_r    <= 1'b0;
        end else begin
            if (pc == SEQ_WAIT) begin
                if (samples.valid) pc <= SEQ_STEP1;
            end else begin
                pc <= (pc == SEQ_STEP7) ? SEQ_WAIT : seq_state_t'(pc + 3'd1);
            end
            if (ld_i1_l) i1_l <= p;
            if (ld_i1_r) i1_r <= p;
            if (ld_i2_l) begin
                i2_l  <= p;
                neg_l <= p[$bits(acc_t)-1];
            end
            if (ld_i2_r) begin
                i2_r      <= p;
                neg_r     <= p[$bits(acc_t)-1];
                dout_r    <= ~p[$bits(acc_t)-1];
                delta_cnt <= delta_cnt + 4'd1;
            end
            if (pc == SEQ_STEP5) dout_l <= ~neg_l;
        end
    end

    // Held input pair
    always_ff @(posedge clk) begin
        if (samples.valid && samples.ready) begin
            s_l <= samples.left;
            s_r <= samples.right;
        end
    end

    dsp_adder u_dsp_adder (
        .clk   (clk),
        .reset (reset),
        .op    (op),
        .dab   (dab),
        .c     (c),
        .p     (p)
    );

endmodule

// ==== logic/sample_pacer.sv ====
// --------------------------------------------------------------------------
// Sample FIFO with modulator tick and audio-period timing
// --------------------------------------------------------------------------
`include "sd_dac_settings.svh"

module sample_pacer
    import audio_pkg::*;
#(
    parameter int LEVEL_W = $clog2(`SD_FIFO_DEPTH + 1)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               enable,
    sample_if.consumer         push,
    sample_if.producer         mod,
    output logic [LEVEL_W-1:0] fifo_level,
    output logic               underflow_set
);

    localparam int PTR_W = $clog2(`SD_FIFO_DEPTH);
    localparam int DIV_W = $clog2(`SD_MOD_DIV);
    localparam int OSR_W = $clog2(`SD_OSR);

    sample_t mem_l [`SD_FIFO_DEPTH];
    sample_t mem_r [`SD_FIFO_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [DIV_W-1:0] div_cnt;
    logic [OSR_W-1:0] osr_cnt;
    logic             tick;
    logic             period;
    logic             do_push;
    logic             do_pop;

    // ------------------------------------------------------------------------
    // Timing and FIFO strobes
    // ------------------------------------------------------------------------
    assign push.ready    = (fifo_level != LEVEL_W'(`SD_FIFO_DEPTH));
    assign do_push       = push.valid && push.ready;
    assign tick          = enable && (div_cnt == DIV_W'(`SD_MOD_DIV - 1));
    assign period        = tick && (osr_cnt == '0);
    assign do_pop        = period && (fifo_level != '0);
    assign underflow_set = period && (fifo_level == '0);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_level <= '0;
            div_cnt    <= '0;
            osr_cnt    <= '0;
            mod.valid  <= 1'b0;
            mod.left   <= '0;
            mod.right  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            fifo_level <= fifo_level + LEVEL_W'(do_push) - LEVEL_W'(do_pop);

            // Counters restart whenever the pacer is disabled
            if (!enable) begin
                div_cnt <= '0;
                osr_cnt <= '0;
            end else begin
                div_cnt <= tick ? '0 : div_cnt + 1'b1;
                if (tick) osr_cnt <= (osr_cnt == OSR_W'(`SD_OSR - 1)) ? '0 : osr_cnt + 1'b1;
            end

            // Empty FIFO keeps the old pair
            if (do_pop) begin
                mod.left  <= mem_l[rd_ptr];
                mod.right <= mem_r[rd_ptr];
            end

            // Held until the modulator takes it
            if (tick)                        mod.valid <= 1'b1;
            else if (mod.valid && mod.ready) mod.valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_l[wr_ptr] <= push.left;
            mem_r[wr_ptr] <= push.right;
        end
    end

endmodule

// ==== logic/wb_sample_port.sv ====
// --------------------------------------------------------------------------
// Wishbone classic slave for sample writes, control and status
// --------------------------------------------------------------------------
`include "sd_dac_settings.svh"

module wb_sample_port
    import audio_pkg::*;
#(
    parameter int LEVEL_W = $clog2(`SD_FIFO_DEPTH + 1)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  wb_addr_t           wb_adr,
    input  logic [31:0]        wb_dat_w,
    output logic [31:0]        wb_dat_r,
    output logic               wb_ack,
    sample_if.producer         push,
    input  logic [LEVEL_W-1:0] fifo_level,
    input  logic               underflow_set,
    output logic               enable
);

    logic    take;
    sample_t left_q;
    logic    overflow;
    logic    underflow;

    // One access per strobe with ack one clock later
    assign take = wb_cyc && wb_stb && !wb_ack;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_ack     <= 1'b0;
            enable     <= 1'b0;
            overflow   <= 1'b0;
            underflow  <= 1'b0;
            push.valid <= 1'b0;
        end else begin
            wb_ack     <= take;
            push.valid <= 1'b0;
            if (take && wb_we) begin
                case (reg_addr_t'(wb_adr))
                    REG_RIGHT: begin
                        // Full FIFO drops the pair
                        if (push.ready) push.valid <= 1'b1;
                        else            overflow   <= 1'b1;
                    end
                    REG_STATUS: begin
                        if (wb_dat_w[8]) overflow  <= 1'b0;
                        if (wb_dat_w[9]) underflow <= 1'b0;
                    end
                    REG_CONTROL: enable <= wb_dat_w[0];
                    default: ;
                endcase
            end
            // Pacer event wins over a clear in the same clock
            if (underflow_set) underflow <= 1'b1;
        end
    end

    // Sample and read-data registers
    always_ff @(posedge clk) begin
        if (take && wb_we && reg_addr_t'(wb_adr) == REG_LEFT) begin
            left_q <= wb_dat_w[`SD_SAMPLE_W-1:0];
        end
        if (take && wb_we && reg_addr_t'(wb_adr) == REG_RIGHT) begin
            push.left  <= left_q;
            push.right <= wb_dat_w[`SD_SAMPLE_W-1:0];
        end
        if (take) begin
            case (reg_addr_t'(wb_adr))
                REG_LEFT:    wb_dat_r <= 32'(left_q);
                REG_STATUS:  wb_dat_r <= {15'd0, enable, 6'd0, underflow, overflow,
                                          8'(fifo_level)};
                REG_CONTROL: wb_dat_r <= {31'd0, enable};
                default:     wb_dat_r <= '0;
            endcase
        end
    end

endmodule

// ==== logic/dsp_adder.sv ====
// --------------------------------------------------------------------------
// Registered 48-bit add/subtract unit with operand select
// --------------------------------------------------------------------------
module dsp_adder
    import dsp_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  dsp_op_t op,
    input  acc_t    dab,
    input  acc_t    c,
    output acc_t    p
);

    acc_t sum_in;
    acc_t sum;

    // Second operand is c on a load, else the running result
    assign sum_in = (op == DSP_LOAD_C) ? c : p;
    assign sum    = (op == DSP_ACC_SUB) ? sum_in - dab : sum_in + dab;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            p <= '0;
        end else if (op != DSP_NONE) begin
            p <= sum;
        end
    end

endmodule

// ==== logic/sample_if.sv ====
// --------------------------------------------------------------------------
// Stereo sample stream with valid/ready handshake
// --------------------------------------------------------------------------
interface sample_if
    import audio_pkg::*;
();

    sample_t left;
    sample_t right;
    logic    valid;
    logic    ready;

    // Pair is transferred when valid and ready are both high
    modport producer (
        output left, right, valid,
        input  ready
    );

    modport consumer (
        input  left, right, valid,
        output ready
    );

endinterface

// ==== logic/audio_pkg.sv ====
// --------------------------------------------------------------------------
// Audio sample types, register map and modulator sequencer steps
// --------------------------------------------------------------------------
`include "sd_dac_settings.svh"

package audio_pkg;

    typedef logic signed [`SD_SAMPLE_W-1:0] sample_t;
    typedef logic [`SD_WB_ADDR_W-1:0] wb_addr_t;

    // Wishbone register map
    typedef enum logic [`SD_WB_ADDR_W-1:0] {
        REG_LEFT    = 2'd0,
        REG_RIGHT   = 2'd1,
        REG_STATUS  = 2'd2,
        REG_CONTROL = 2'd3
    } reg_addr_t;

    // Modulator program counter
    typedef enum logic [2:0] {
        SEQ_WAIT, SEQ_STEP1, SEQ_STEP2, SEQ_STEP3,
        SEQ_STEP4, SEQ_STEP5, SEQ_STEP6, SEQ_STEP7
    } seq_state_t;

endpackage

// ==== logic/dsp_pkg.sv ====
// --------------------------------------------------------------------------
// Arithmetic types for the shared modulator adder
// --------------------------------------------------------------------------
`include "sd_dac_settings.svh"

package dsp_pkg;

    // Accumulator and adder operand word
    typedef logic signed [`SD_ACC_W-1:0] acc_t;

    // Adder operations
    //   DSP_NONE     hold p
    //   DSP_LOAD_C   p <= dab + c
    //   DSP_ACC_ADD  p <= p + dab
    //   DSP_ACC_SUB  p <= p - dab
    typedef enum logic [1:0] {
        DSP_NONE    = 2'd0,
        DSP_LOAD_C  = 2'd1,
        DSP_ACC_ADD = 2'd2,
        DSP_ACC_SUB = 2'd3
    } dsp_op_t;

endpackage

// ==== include/sd_dac_settings.svh ====
// --------------------------------------------------------------------------
// Sigma-delta DAC core build settings
// Widths, FIFO depth and modulator timing shared by all blocks
// --------------------------------------------------------------------------
`ifndef SD_DAC_SETTINGS_SVH
`define SD_DAC_SETTINGS_SVH

// Datapath widths
`define SD_SAMPLE_W 18
`define SD_ACC_W 48

// Sample FIFO entries, a power of two
`define SD_FIFO_DEPTH 8

// Clocks per modulator tick
`define SD_MOD_DIV 16
// Modulator ticks per audio sample
`define SD_OSR 8

`define SD_WB_ADDR_W 2

`endif
